// ==== source/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Datapath widths
`define NB_INST     32
`define NB_DATA     32
`define NB_PC       32
`define NB_REG      5

// Instruction field widths
`define NB_OPCODE   6
`define NB_FUNCT    6

`define HLT_OPCODE  6'b111111  // Stops the pipeline

`endif

// ==== source/mips_pkg.sv ====
`default_nettype none

`include "mips_params.svh"

package mips_pkg;

    typedef enum logic [`NB_OPCODE-1:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDI  = 6'b001000,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_LUI   = 6'b001111,
        OP_LB    = 6'b100000,
        OP_LH    = 6'b100001,
        OP_LW    = 6'b100011,
        OP_SB    = 6'b101000,
        OP_SH    = 6'b101001,
        OP_SW    = 6'b101011,
        OP_HLT   = `HLT_OPCODE
    } opcode_e;

    typedef enum logic [`NB_FUNCT-1:0] {
        FN_SLL   = 6'b000000,
        FN_SRL   = 6'b000010,
        FN_JR    = 6'b001000,
        FN_JALR  = 6'b001001,
        FN_ADDU  = 6'b100001,
        FN_SUBU  = 6'b100011,
        FN_AND   = 6'b100100,
        FN_OR    = 6'b100101,
        FN_XOR   = 6'b100110
    } funct_e;

    // Same width as the opcode, as the EX stage expects
    typedef enum logic [`NB_OPCODE-1:0] {
        ALU_NOP  = 6'd0,    // Inactive value after reset and flush
        ALU_ADD  = 6'd1,
        ALU_SUB  = 6'd2,
        ALU_AND  = 6'd3,
        ALU_OR   = 6'd4,
        ALU_XOR  = 6'd5,
        ALU_SLL  = 6'd6,
        ALU_SRL  = 6'd7,
        ALU_LUI  = 6'd8
    } alu_op_e;

endpackage

`default_nettype wire

// ==== source/regfile_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_params.svh"

interface regfile_if;

    logic                   reg_write;      // From WB
    logic [`NB_REG-1:0]     write_reg;
    logic [`NB_DATA-1:0]    write_data;
    logic [`NB_REG-1:0]     read_reg_a;     // rs field
    logic [`NB_REG-1:0]     read_reg_b;     // rt field
    logic [`NB_DATA-1:0]    data_a;
    logic [`NB_DATA-1:0]    data_b;

    modport bank (
        input  reg_write, write_reg, write_data, read_reg_a, read_reg_b,
        output data_a, data_b
    );

    modport stage (
        output reg_write, write_reg, write_data, read_reg_a, read_reg_b,
        input  data_a, data_b
    );

endinterface

`default_nettype wire

// ==== source/control_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  logic                i_clock,
    input  logic                i_rst_n,
    input  logic                i_enable,       // Debug unit hold
    input  logic                i_ctrl_sel,     // Flush from stall unit
    input  mips_pkg::opcode_e   i_opcode,
    input  mips_pkg::funct_e    i_funct,
    output logic                o_reg_dest,     // EX
    output logic                o_signed,
    output mips_pkg::alu_op_e   o_alu_op,       // EX
    output logic                o_alu_src,      // EX
    output logic                o_mem_read,     // MEM
    output logic                o_mem_write,    // MEM
    output logic                o_branch,       // MEM
    output logic                o_reg_write,    // WB
    output logic                o_mem_to_reg,   // WB
    output logic                o_jump,
    output logic                o_jr_jalr,      // IF takes target from rs
    output logic                o_hlt,
    output logic                o_byte_en,
    output logic                o_halfword_en,
    output logic                o_word_en
);

    logic               nxt_reg_dest, nxt_signed, nxt_alu_src;
    logic               nxt_mem_read, nxt_mem_write, nxt_branch;
    logic               nxt_reg_write, nxt_mem_to_reg, nxt_jump;
    logic               nxt_jr_jalr, nxt_hlt;
    logic               nxt_byte_en, nxt_halfword_en, nxt_word_en;
    mips_pkg::alu_op_e  nxt_alu_op;

    always_comb begin
        nxt_reg_dest    = 1'b0;
        nxt_signed      = 1'b0;
        nxt_alu_op      = mips_pkg::ALU_NOP;
        nxt_alu_src     = 1'b0;
        nxt_mem_read    = 1'b0;
        nxt_mem_write   = 1'b0;
        nxt_branch      = 1'b0;
        nxt_reg_write   = 1'b0;
        nxt_mem_to_reg  = 1'b0;
        nxt_jump        = 1'b0;
        nxt_jr_jalr     = 1'b0;
        nxt_hlt         = 1'b0;
        nxt_byte_en     = 1'b0;
        nxt_halfword_en = 1'b0;
        nxt_word_en     = 1'b0;

        case (i_opcode)
            mips_pkg::OP_RTYPE: begin
                case (i_funct)
                    mips_pkg::FN_ADDU: nxt_alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: nxt_alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  nxt_alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   nxt_alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  nxt_alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLL:  nxt_alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  nxt_alu_op = mips_pkg::ALU_SRL;
                    default:           nxt_alu_op = mips_pkg::ALU_NOP;
                endcase
                // ALU functs write rd, jumps through rs handled apart
                nxt_reg_dest  = (nxt_alu_op != mips_pkg::ALU_NOP);
                nxt_reg_write = (nxt_alu_op != mips_pkg::ALU_NOP)
                                || (i_funct == mips_pkg::FN_JALR);
                nxt_jump      = (i_funct == mips_pkg::FN_JR) || (i_funct == mips_pkg::FN_JALR);
                nxt_jr_jalr   = nxt_jump;
            end
            mips_pkg::OP_ADDI: begin
                nxt_alu_src   = 1'b1;
                nxt_signed    = 1'b1;
                nxt_reg_write = 1'b1;
                nxt_alu_op    = mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI: begin
                nxt_alu_src   = 1'b1;
                nxt_reg_write = 1'b1;
                nxt_alu_op    = (i_opcode == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND
                                                                 : mips_pkg::ALU_OR;
            end
            mips_pkg::OP_LUI: begin
                nxt_alu_src   = 1'b1;
                nxt_reg_write = 1'b1;
                nxt_alu_op    = mips_pkg::ALU_LUI;
            end
            mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW: begin
                nxt_mem_read    = 1'b1;
                nxt_mem_to_reg  = 1'b1;
                nxt_alu_src     = 1'b1;
                nxt_reg_write   = 1'b1;
                nxt_signed      = 1'b1;
                nxt_alu_op      = mips_pkg::ALU_ADD;   // Base plus offset
                nxt_byte_en     = (i_opcode == mips_pkg::OP_LB);
                nxt_halfword_en = (i_opcode == mips_pkg::OP_LH);
                nxt_word_en     = (i_opcode == mips_pkg::OP_LW);
            end
            mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW: begin
                nxt_mem_write   = 1'b1;
                nxt_alu_src     = 1'b1;
                nxt_signed      = 1'b1;
                nxt_alu_op      = mips_pkg::ALU_ADD;
                nxt_byte_en     = (i_opcode == mips_pkg::OP_SB);
                nxt_halfword_en = (i_opcode == mips_pkg::OP_SH);
                nxt_word_en     = (i_opcode == mips_pkg::OP_SW);
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                nxt_branch = 1'b1;
                nxt_signed = 1'b1;
                nxt_alu_op = mips_pkg::ALU_SUB;         // Compare by subtraction
            end
            mips_pkg::OP_J:   nxt_jump = 1'b1;
            mips_pkg::OP_JAL: begin
                nxt_jump      = 1'b1;
                nxt_reg_write = 1'b1;                   // Link into r31
            end
            mips_pkg::OP_HLT: nxt_hlt = 1'b1;
            default: ;                                  // Illegal code stays inactive
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n || i_ctrl_sel) begin               // Reset or flush
            o_reg_dest    <= 1'b0;
            o_signed      <= 1'b0;
            o_alu_op      <= mips_pkg::ALU_NOP;
            o_alu_src     <= 1'b0;
            o_mem_read    <= 1'b0;
            o_mem_write   <= 1'b0;
            o_branch      <= 1'b0;
            o_reg_write   <= 1'b0;
            o_mem_to_reg  <= 1'b0;
            o_jump        <= 1'b0;
            o_jr_jalr     <= 1'b0;
            o_hlt         <= 1'b0;
            o_byte_en     <= 1'b0;
            o_halfword_en <= 1'b0;
            o_word_en     <= 1'b0;
        end else if (i_enable) begin
            o_reg_dest    <= nxt_reg_dest;
            o_signed      <= nxt_signed;
            o_alu_op      <= nxt_alu_op;
            o_alu_src     <= nxt_alu_src;
            o_mem_read    <= nxt_mem_read;
            o_mem_write   <= nxt_mem_write;
            o_branch      <= nxt_branch;
            o_reg_write   <= nxt_reg_write;
            o_mem_to_reg  <= nxt_mem_to_reg;
            o_jump        <= nxt_jump;
            o_jr_jalr     <= nxt_jr_jalr;
            o_hlt         <= nxt_hlt;
            o_byte_en     <= nxt_byte_en;
            o_halfword_en <= nxt_halfword_en;
            o_word_en     <= nxt_word_en;
        end
    end

    // MEM stage sees a single access width
    a_one_width: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        $onehot0({o_byte_en, o_halfword_en, o_word_en}));

    a_rd_wr_excl: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !(o_mem_read && o_mem_write));

endmodule

`default_nettype wire

// ==== source/register_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_params.svh"

module register_bank (
    input  logic                i_clock,
    input  logic                i_rst_n,
    input  logic                i_enable,           // Debug unit write gate
    input  logic                i_read_enable,      // Debug unit takes port A
    input  logic [`NB_REG-1:0]  i_read_address,     // Debug unit
    regfile_if.bank             rf
);

    localparam int N_REGS = 2 ** `NB_REG;

    logic [`NB_DATA-1:0] regs [N_REGS];
    logic [`NB_REG-1:0]  addr_a;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_enable && rf.reg_write && (rf.write_reg != '0)) begin
            regs[rf.write_reg] <= rf.write_data;
        end
    end

    // Port A is shared with the debug read
    assign addr_a = i_read_enable ? i_read_address : rf.read_reg_a;

    // Reads see the old value until the write edge
    always_comb begin
        if (addr_a == '0) begin
            rf.data_a = '0;
        end else begin
            rf.data_a = regs[addr_a];
        end

        if (rf.read_reg_b == '0) begin
            rf.data_b = '0;
        end else begin
            rf.data_b = regs[rf.read_reg_b];
        end
    end

    // r0 holds zero across every write from WB
    a_r0_zero: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        regs[0] == '0);

endmodule

`default_nettype wire

// ==== source/imm_jump_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_params.svh"

module imm_jump_gen (
    input  logic                i_clock,
    input  logic                i_rst_n,
    input  logic                i_enable,       // Pipeline advance
    input  logic [25:0]         i_inst,         // Jump index field
    input  logic [3:0]          i_pc_high,      // PC[31:28]
    output logic [`NB_DATA-1:0] o_immediate,
    output logic [`NB_DATA-1:0] o_shamt,
    output logic [`NB_PC-1:0]   o_jump_addr
);

    // Sign-extended 16-bit immediate
    assign o_immediate = {{(`NB_DATA-16){i_inst[15]}}, i_inst[15:0]};

    // Shift amount, unsigned
    assign o_shamt     = {{(`NB_DATA-5){1'b0}}, i_inst[10:6]};

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_jump_addr <= '0;
        end else if (i_enable) begin
            o_jump_addr <= {i_pc_high, i_inst, 2'b00};  // Word aligned target
        end
    end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_params.svh"

module decode_stage (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_pipeline_enable,
    input  logic                    i_cu_enable,        // Debug unit
    input  logic                    i_rb_enable,        // Debug unit
    input  logic                    i_rb_read_enable,   // Debug unit
    input  logic [`NB_REG-1:0]      i_rb_read_address,  // Debug unit
    input  logic [`NB_INST-1:0]     i_inst,
    input  logic [`NB_PC-1:0]       i_pc,
    input  logic [`NB_DATA-1:0]     i_write_data,       // From WB
    input  logic [`NB_REG-1:0]      i_write_reg,        // From WB
    input  logic                    i_reg_write,        // From WB
    input  logic                    i_ctrl_sel,         // 1 flushes the controls
    output logic                    o_reg_dest,
    output logic                    o_signed,
    output logic [`NB_OPCODE-1:0]   o_alu_op,
    output logic                    o_alu_src,
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output logic                    o_branch,
    output logic                    o_reg_write,
    output logic                    o_mem_to_reg,
    output logic                    o_jump,
    output logic                    o_jr_jalr,
    output logic                    o_hlt,
    output logic                    o_byte_en,
    output logic                    o_halfword_en,
    output logic                    o_word_en,
    output logic [`NB_PC-1:0]       o_jump_address,
    output logic [`NB_DATA-1:0]     o_data_a,
    output logic [`NB_DATA-1:0]     o_data_b,
    output logic [`NB_DATA-1:0]     o_immediate,
    output logic [`NB_DATA-1:0]     o_shamt,
    output logic [`NB_REG-1:0]      o_rs,
    output logic [`NB_REG-1:0]      o_rt,
    output logic [`NB_REG-1:0]      o_rd,
    output logic [`NB_PC-1:0]       o_pc
);

    regfile_if rf ();

    mips_pkg::opcode_e  opcode;
    mips_pkg::funct_e   funct;
    mips_pkg::alu_op_e  alu_op;

    assign opcode = mips_pkg::opcode_e'(i_inst[31:26]);  // Illegal codes pass through
    assign funct  = mips_pkg::funct_e'(i_inst[5:0]);

    // Stage side of the register bank
    assign rf.reg_write  = i_reg_write;
    assign rf.write_reg  = i_write_reg;
    assign rf.write_data = i_write_data;
    assign rf.read_reg_a = i_inst[25:21];
    assign rf.read_reg_b = i_inst[20:16];
    assign o_data_a      = rf.data_a;
    assign o_data_b      = rf.data_b;

    control_unit u_control_unit (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_enable      (i_cu_enable),
        .i_ctrl_sel    (i_ctrl_sel),
        .i_opcode      (opcode),
        .i_funct       (funct),
        .o_reg_dest    (o_reg_dest),
        .o_signed      (o_signed),
        .o_alu_op      (alu_op),
        .o_alu_src     (o_alu_src),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_branch      (o_branch),
        .o_reg_write   (o_reg_write),
        .o_mem_to_reg  (o_mem_to_reg),
        .o_jump        (o_jump),
        .o_jr_jalr     (o_jr_jalr),
        .o_hlt         (o_hlt),
        .o_byte_en     (o_byte_en),
        .o_halfword_en (o_halfword_en),
        .o_word_en     (o_word_en)
    );

    assign o_alu_op = alu_op;

    register_bank u_register_bank (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_enable       (i_rb_enable),
        .i_read_enable  (i_rb_read_enable),
        .i_read_address (i_rb_read_address),
        .rf             (rf.bank)
    );

    imm_jump_gen u_imm_jump_gen (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_enable    (i_pipeline_enable),
        .i_inst      (i_inst[25:0]),
        .i_pc_high   (i_pc[31:28]),     // Upper bits of PC+4
        .o_immediate (o_immediate),
        .o_shamt     (o_shamt),
        .o_jump_addr (o_jump_address)
    );

    // Register fields forwarded to EX
    assign o_rs = i_inst[25:21];
    assign o_rt = i_inst[20:16];
    assign o_rd = i_inst[15:11];
    assign o_pc = i_pc;

endmodule

`default_nettype wire

// ==== test/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic o_clock
);

    localparam int HALF_PERIOD = 20;    // 40 ns period

    initial begin
        o_clock = 1'b0;
    end

    always #HALF_PERIOD o_clock = ~o_clock;

endmodule

`default_nettype wire

// ==== test/decode_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_params.svh"

module decode_stage_tb;

    localparam int NUM_CYCLES   = 500;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT   = 50;

    // Same field order as the DUT control outputs
    typedef struct packed {
        logic reg_dest, sgn;
        mips_pkg::alu_op_e alu_op;
        logic alu_src, mem_read, mem_write, branch, reg_write, mem_to_reg;
        logic jump, jr_jalr, hlt, byte_en, half_en, word_en;
    } ctrl_t;

    logic i_clock, i_rst_n, i_pipeline_enable, i_cu_enable, i_rb_enable;
    logic i_rb_read_enable, i_reg_write, i_ctrl_sel;
    logic [`NB_REG-1:0]  i_rb_read_address, i_write_reg;
    logic [`NB_INST-1:0] i_inst;
    logic [`NB_PC-1:0]   i_pc;
    logic [`NB_DATA-1:0] i_write_data;
    logic o_reg_dest, o_signed, o_alu_src, o_mem_read, o_mem_write, o_branch;
    logic o_reg_write, o_mem_to_reg, o_jump, o_jr_jalr, o_hlt;
    logic o_byte_en, o_halfword_en, o_word_en;
    logic [`NB_OPCODE-1:0] o_alu_op;
    logic [`NB_DATA-1:0]   o_jump_address, o_data_a, o_data_b, o_immediate, o_shamt, o_pc;
    logic [`NB_REG-1:0]    o_rs, o_rt, o_rd;

    logic [`NB_DATA-1:0] model_regs [32];
    ctrl_t               model_ctrl;
    logic [`NB_PC-1:0]   model_jump;
    int ctrl_errors  = 0;
    int data_errors  = 0;
    int field_errors = 0;
    int wait_count;

    logic [5:0] opcode_list [16] = '{mips_pkg::OP_RTYPE, mips_pkg::OP_J, mips_pkg::OP_JAL,
        mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_ADDI, mips_pkg::OP_ANDI,
        mips_pkg::OP_ORI, mips_pkg::OP_LUI, mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
        mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW, mips_pkg::OP_HLT};
    logic [5:0] illegal_ops [4] = '{6'b000001, 6'b010000, 6'b011100, 6'b110011};
    // Legal functs weighted up and two illegal ones last
    logic [5:0] funct_list [16] = '{mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_JR,
        mips_pkg::FN_JALR, mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND,
        mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_ADDU, mips_pkg::FN_SUBU,
        mips_pkg::FN_OR, mips_pkg::FN_JR, mips_pkg::FN_JALR, 6'b111000, 6'b000111};

    clock_gen u_clock_gen (.o_clock(i_clock));

    decode_stage UUT (.*);

    function automatic bit chance(input int pct);
        return ($urandom % 100) < pct;
    endfunction

    function automatic ctrl_t expected_ctrl(input logic [5:0] op, input logic [5:0] fn);
        ctrl_t c;
        c = '0;                                     // All inactive with alu_op ALU_NOP
        case (op)
            mips_pkg::OP_RTYPE: begin
                case (fn)
                    mips_pkg::FN_ADDU: c.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: c.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  c.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   c.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  c.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLL:  c.alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  c.alu_op = mips_pkg::ALU_SRL;
                    default: ;
                endcase
                c.jump      = (fn == mips_pkg::FN_JR) || (fn == mips_pkg::FN_JALR);
                c.jr_jalr   = c.jump;
                c.reg_dest  = (c.alu_op != mips_pkg::ALU_NOP);
                c.reg_write = c.reg_dest || (fn == mips_pkg::FN_JALR);
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
                c.alu_src   = 1'b1;
                c.reg_write = 1'b1;
                c.sgn       = (op == mips_pkg::OP_ADDI);
                c.alu_op    = (op == mips_pkg::OP_ADDI) ? mips_pkg::ALU_ADD :
                              (op == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND :
                              (op == mips_pkg::OP_ORI)  ? mips_pkg::ALU_OR : mips_pkg::ALU_LUI;
            end
            mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
            mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW: begin
                c.mem_read   = op[5:3] == 3'b100;   // Loads
                c.mem_write  = op[5:3] == 3'b101;   // Stores
                c.mem_to_reg = c.mem_read;
                c.reg_write  = c.mem_read;
                c.alu_src    = 1'b1;
                c.sgn        = 1'b1;
                c.alu_op     = mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                c.branch = 1'b1;
                c.sgn    = 1'b1;
                c.alu_op = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_J:   c.jump = 1'b1;
            mips_pkg::OP_JAL: begin
                c.jump      = 1'b1;
                c.reg_write = 1'b1;
            end
            mips_pkg::OP_HLT: c.hlt = 1'b1;
            default: ;
        endcase
        c.byte_en = (op == mips_pkg::OP_LB) || (op == mips_pkg::OP_SB);
        c.half_en = (op == mips_pkg::OP_LH) || (op == mips_pkg::OP_SH);
        c.word_en = (op == mips_pkg::OP_LW) || (op == mips_pkg::OP_SW);
        return c;
    endfunction

    task automatic check_ctrl(input ctrl_t got, input ctrl_t exp);
        if (got !== exp) begin
            ctrl_errors++;
            $display("error at %0t ns: controls %h, expected %h (alu_op %s)",
                     $time, got, exp, exp.alu_op.name());
        end
    endtask

    task automatic check_data(input string what, input logic [`NB_DATA-1:0] got,
                              input logic [`NB_DATA-1:0] exp);
        if (got !== exp) begin
            data_errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg_field(input string what, input logic [`NB_REG-1:0] got,
                                   input logic [`NB_REG-1:0] exp);
        if (got !== exp) begin
            field_errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Runs right after a rising edge on the inputs the DUT sampled
    task automatic update_model();
        if (!i_rst_n) begin
            model_ctrl = '0;
            model_jump = '0;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
        end else begin
            if (i_ctrl_sel) begin
                model_ctrl = '0;
            end else if (i_cu_enable) begin
                model_ctrl = expected_ctrl(i_inst[31:26], i_inst[5:0]);
            end
            if (i_pipeline_enable) begin
                model_jump = {i_pc[31:28], i_inst[25:0], 2'b00};
            end
            if (i_rb_enable && i_reg_write && (i_write_reg != '0)) begin
                model_regs[i_write_reg] = i_write_data;
            end
        end
    endtask

    task automatic drive_random();
        logic [31:0] r_op;
        logic [31:0] r_inst;
        logic [31:0] r_fn;
        logic [31:0] r_misc;
        logic [5:0]  op;
        r_op   = $urandom;
        r_inst = $urandom;
        r_fn   = $urandom;
        r_misc = $urandom;
        if (r_op[7:4] == 4'd0) begin
            op = illegal_ops[r_op[1:0]];
        end else if (r_op[7:6] == 2'b11) begin
            op = mips_pkg::OP_RTYPE;                // Extra weight on functs
        end else begin
            op = opcode_list[r_op[3:0]];
        end
        i_inst            <= {op, r_inst[25:6], funct_list[r_fn[3:0]]};
        i_pc              <= $urandom;
        i_write_data      <= $urandom;
        i_write_reg       <= chance(50) ? r_inst[25:21] : r_misc[4:0];  // Often hits rs
        i_reg_write       <= chance(70);
        i_rb_enable       <= chance(85);
        i_cu_enable       <= chance(85);
        i_ctrl_sel        <= chance(10);
        i_pipeline_enable <= chance(80);
        i_rb_read_enable  <= chance(15);
        i_rb_read_address <= r_misc[12:8];
    endtask

    // Sampled at the falling edge away from input changes
    task automatic check_outputs();
        ctrl_t              got;
        logic [`NB_REG-1:0] addr_a;
        got = {o_reg_dest, o_signed, o_alu_op, o_alu_src, o_mem_read, o_mem_write, o_branch,
               o_reg_write, o_mem_to_reg, o_jump, o_jr_jalr, o_hlt,
               o_byte_en, o_halfword_en, o_word_en};
        check_ctrl(got, model_ctrl);
        addr_a = i_rb_read_enable ? i_rb_read_address : i_inst[25:21];
        check_data("data_a", o_data_a, model_regs[addr_a]);
        check_data("data_b", o_data_b, model_regs[i_inst[20:16]]);
        check_data("immediate", o_immediate, {{16{i_inst[15]}}, i_inst[15:0]});
        check_data("shamt", o_shamt, {27'b0, i_inst[10:6]});
        check_data("pc", o_pc, i_pc);
        check_data("jump_address", o_jump_address, model_jump);
        check_reg_field("rs", o_rs, i_inst[25:21]);
        check_reg_field("rt", o_rt, i_inst[20:16]);
        check_reg_field("rd", o_rd, i_inst[15:11]);
    endtask

    initial begin
        i_inst            = $urandom(32'h5bff);     // Random rs field while reset is held
        i_rst_n           = 1'b0;
        i_pipeline_enable = 1'b0;
        i_cu_enable       = 1'b0;
        i_rb_enable       = 1'b0;
        i_rb_read_enable  = 1'b0;
        i_rb_read_address = '0;
        i_pc              = '0;
        i_write_data      = '0;
        i_write_reg       = '0;
        i_reg_write       = 1'b0;
        i_ctrl_sel        = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge i_clock);
            update_model();
        end
        // Outputs must settle to their reset values
        wait_count = 0;
        while (((o_jump_address !== '0) || (o_alu_op !== '0) || (o_data_a !== '0))
               && (wait_count < WAIT_LIMIT)) begin
            @(negedge i_clock);
            wait_count++;
        end
        if (wait_count >= WAIT_LIMIT) begin
            $display("Timeout: DUT outputs did not clear while reset was held");
            $display("Testbench failed");
        end else begin
            @(posedge i_clock);
            update_model();
            i_rst_n <= 1'b1;
            drive_random();
            for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
                @(negedge i_clock);
                check_outputs();
                @(posedge i_clock);
                update_model();
                drive_random();
            end
            @(negedge i_clock);
            check_outputs();
            $display("Errors: control %0d, data %0d, field %0d",
                     ctrl_errors, data_errors, field_errors);
            if ((ctrl_errors + data_errors + field_errors) == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/mips_pkg.sv
source/regfile_if.sv
source/control_unit.sv
source/register_bank.sv
source/imm_jump_gen.sv
source/decode_stage.sv
test/clock_gen.sv
test/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -f "$LOG"
verilator --binary --timing --assert -f vlog.f --top-module decode_stage_tb > "$LOG" 2>&1 \
    && ./obj_dir/Vdecode_stage_tb >> "$LOG" 2>&1 \
    || { cat "$LOG"; echo "Build or simulation did not complete"; exit 1; }
cat "$LOG"
grep -q "Testbench failed" "$LOG" && exit 1 || exit 0
